// File: common/uart_pkg.sv
`default_nettype none

package uart_pkg;

	// serial line timing in clocks
	localparam int CLKS_PER_BIT = 16;
	localparam int HALF_BIT = CLKS_PER_BIT / 2;
	localparam int DATA_BITS = 8;

	// counter widths for the receiver
	localparam int CNT_BITS = $clog2(CLKS_PER_BIT);
	localparam int IDX_BITS = $clog2(DATA_BITS);

	typedef logic [DATA_BITS-1:0] uart_byte_t;

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} rx_state_e;

endpackage

`default_nettype wire

// File: common/audio_pkg.sv
`default_nettype none

package audio_pkg;

	// unsigned pcm samples
	localparam int SAMPLE_BITS = 8;
	typedef logic [SAMPLE_BITS-1:0] sample_t;

	// sample buffer sizing
	localparam int FIFO_DEPTH = 16;
	localparam int PTR_BITS = $clog2(FIFO_DEPTH);

	// fill count must reach FIFO_DEPTH itself, hence one extra bit
	localparam int FILL_BITS = 5;
	typedef logic [FILL_BITS-1:0] fill_t;

	// clear-to-send watermarks
	localparam int HIGH_MARK = 12;
	localparam int LOW_MARK = 4;

	// one output sample every 2**SAMPLE_BITS clocks
	// so the ones count per period equals the sample value
	localparam int SAMPLE_PERIOD = 256;

endpackage

`default_nettype wire

// File: uart_rx/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  logic                 CLK_IN,
	input  logic                 rst_n_i,
	input  logic                 rx_i,
	output logic                 byte_valid_o,
	input  logic                 byte_ready_i,
	output uart_pkg::uart_byte_t byte_o,
	output logic                 frame_err_o,
	output logic                 overrun_o
);
	import uart_pkg::*;

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	rx_state_e state;
	logic [CNT_BITS-1:0] clk_cnt;
	logic [IDX_BITS-1:0] bit_idx;
	uart_byte_t shift;
	logic bit_done;

	assign bit_done = (clk_cnt == CNT_BITS'(CLKS_PER_BIT - 1));

	// line idles high
	always_ff @(posedge CLK_IN or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge CLK_IN or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state <= IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			byte_valid_o <= 1'b0;
			frame_err_o <= 1'b0;
		end else begin
			byte_valid_o <= 1'b0;
			frame_err_o <= 1'b0;
			case (state)
				IDLE: begin
					clk_cnt <= '0;
					if (rx_prev && !rx_sync)
						state <= START;
				end
				START: begin
					// line must still be low half a bit later
					if (clk_cnt == CNT_BITS'(HALF_BIT - 1)) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? IDLE : DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				DATA: begin
					if (bit_done) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == IDX_BITS'(DATA_BITS - 1))
							state <= STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				STOP: begin
					if (bit_done) begin
						clk_cnt <= '0;
						state <= IDLE;
						if (rx_sync)
							byte_valid_o <= 1'b1;
						else
							frame_err_o <= 1'b1;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// lsb first, shifted in from the top
	always_ff @(posedge CLK_IN) begin
		if (state == DATA && bit_done)
			shift <= {rx_sync, shift[DATA_BITS-1:1]};
	end

	assign byte_o = shift;

	// no way to stall the line, a refused byte is simply lost
	assign overrun_o = byte_valid_o & ~byte_ready_i;

endmodule

`default_nettype wire

// File: sample_fifo/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo (
	input  logic                CLK_IN,
	input  logic                rst_n_i,
	input  logic                in_valid_i,
	output logic                in_ready_o,
	input  audio_pkg::sample_t  in_data_i,
	output logic                out_valid_o,
	input  logic                out_ready_i,
	output audio_pkg::sample_t  out_data_o,
	output audio_pkg::fill_t    fill_o
);
	import audio_pkg::*;

	sample_t mem [FIFO_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	fill_t count;
	logic wr_en;
	logic rd_en;

	assign in_ready_o = (count != FILL_BITS'(FIFO_DEPTH));
	assign out_valid_o = (count != '0);
	assign wr_en = in_valid_i & in_ready_o;
	assign rd_en = out_valid_o & out_ready_i;

	// head entry shown ahead of the read
	assign out_data_o = mem[rd_ptr];
	assign fill_o = count;

	always_ff @(posedge CLK_IN) begin
		if (wr_en)
			mem[wr_ptr] <= in_data_i;
	end

	// pointers wrap naturally at FIFO_DEPTH
	always_ff @(posedge CLK_IN or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous read and write leaves the count alone
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/flow_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module flow_ctrl (
	input  logic             CLK_IN,
	input  logic             rst_n_i,
	input  audio_pkg::fill_t fill_i,
	output logic             cts_o
);
	import audio_pkg::*;

	logic at_high;
	logic at_low;

	assign at_high = (fill_i >= FILL_BITS'(HIGH_MARK));
	assign at_low = (fill_i <= FILL_BITS'(LOW_MARK));

	// hysteresis, hold between the marks
	always_ff @(posedge CLK_IN or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cts_o <= 1'b1;
		end else begin
			if (at_high)
				cts_o <= 1'b0;
			else if (at_low)
				cts_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/sample_player.sv
`timescale 1ns/1ps
`default_nettype none

module sample_player (
	input  logic               CLK_IN,
	input  logic               rst_n_i,
	input  logic               sample_valid_i,
	output logic               sample_ready_o,
	input  audio_pkg::sample_t sample_i,
	output logic               dac_o,
	output logic               strobe_o,
	output logic               underrun_o
);
	import audio_pkg::*;

	logic [SAMPLE_BITS-1:0] period_cnt;
	logic tick;
	sample_t held;
	sample_t acc;
	sample_t acc_base;
	sample_t add_val;
	logic underrun_nxt;
	logic [SAMPLE_BITS:0] sum;

	// last cycle of each period
	assign tick = (period_cnt == SAMPLE_BITS'(SAMPLE_PERIOD - 1));
	assign sample_ready_o = tick;

	// restart the modulator with the incoming sample on a tick
	assign acc_base = tick ? '0 : acc;
	assign add_val = tick ? (sample_valid_i ? sample_i : '0) : held;
	assign underrun_nxt = tick ? ~sample_valid_i : underrun_o;
	assign sum = {1'b0, acc_base} + {1'b0, add_val};

	always_ff @(posedge CLK_IN) begin
		if (tick && sample_valid_i)
			held <= sample_i;
	end

	always_ff @(posedge CLK_IN or negedge rst_n_i) begin
		if (!rst_n_i) begin
			period_cnt <= '0;
			strobe_o <= 1'b0;
			underrun_o <= 1'b1;
			acc <= '0;
			dac_o <= 1'b0;
		end else begin
			period_cnt <= period_cnt + 1'b1;
			strobe_o <= tick;
			underrun_o <= underrun_nxt;
			acc <= sum[SAMPLE_BITS-1:0];
			// carry out is the bitstream, silenced on underrun
			dac_o <= sum[SAMPLE_BITS] & ~underrun_nxt;
		end
	end

endmodule

`default_nettype wire

// File: verilog/audio_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

module audio_stream_top (
	input  logic             CLK_IN,
	input  logic             rst_n_i,
	input  logic             uart_rx_i,
	output logic             uart_cts_o,
	output logic             dac_o,
	output logic             strobe_o,
	output logic             underrun_o,
	output logic             overrun_o,
	output logic             frame_err_o,
	output audio_pkg::fill_t fill_o
);
	import uart_pkg::*;
	import audio_pkg::*;

	// byte link
	logic byte_valid;
	logic byte_ready;
	uart_byte_t byte_data;

	// sample link
	logic smp_valid;
	logic smp_ready;
	sample_t smp_data;

	fill_t fill;

	uart_rx u_uart_rx (
		.CLK_IN       (CLK_IN),
		.rst_n_i      (rst_n_i),
		.rx_i         (uart_rx_i),
		.byte_valid_o (byte_valid),
		.byte_ready_i (byte_ready),
		.byte_o       (byte_data),
		.frame_err_o  (frame_err_o),
		.overrun_o    (overrun_o)
	);

	sample_fifo u_sample_fifo (
		.CLK_IN      (CLK_IN),
		.rst_n_i     (rst_n_i),
		.in_valid_i  (byte_valid),
		.in_ready_o  (byte_ready),
		.in_data_i   (byte_data),
		.out_valid_o (smp_valid),
		.out_ready_i (smp_ready),
		.out_data_o  (smp_data),
		.fill_o      (fill)
	);

	flow_ctrl u_flow_ctrl (
		.CLK_IN  (CLK_IN),
		.rst_n_i (rst_n_i),
		.fill_i  (fill),
		.cts_o   (uart_cts_o)
	);

	sample_player u_sample_player (
		.CLK_IN         (CLK_IN),
		.rst_n_i        (rst_n_i),
		.sample_valid_i (smp_valid),
		.sample_ready_o (smp_ready),
		.sample_i       (smp_data),
		.dac_o          (dac_o),
		.strobe_o       (strobe_o),
		.underrun_o     (underrun_o)
	);

	assign fill_o = fill;

endmodule

`default_nettype wire

// File: tests/audio_stream_chk.sv
`timescale 1ns/1ps
`default_nettype none

module audio_stream_chk (
	input logic             CLK_IN,
	input logic             rst_n_i,
	input logic             dac_o,
	input logic             strobe_o,
	input logic             underrun_o,
	input logic             overrun_o,
	input audio_pkg::fill_t fill_o
);
	import audio_pkg::*;

	logic [SAMPLE_BITS:0] since_strobe;
	logic seen_strobe;

	// cycles since the last strobe, saturating
	always_ff @(posedge CLK_IN or negedge rst_n_i) begin
		if (!rst_n_i) begin
			since_strobe <= '0;
			seen_strobe <= 1'b0;
		end else if (strobe_o) begin
			since_strobe <= '0;
			seen_strobe <= 1'b1;
		end else if (since_strobe != '1) begin
			since_strobe <= since_strobe + 1'b1;
		end
	end

	fill_bounded: assert property (@(posedge CLK_IN) disable iff (!rst_n_i)
		fill_o <= FILL_BITS'(FIFO_DEPTH))
		else $error("fill count above the FIFO depth");

	// strobe exactly one sample period after the previous one
	strobe_spacing: assert property (@(posedge CLK_IN) disable iff (!rst_n_i)
		seen_strobe |-> (strobe_o == (since_strobe == (SAMPLE_BITS+1)'(SAMPLE_PERIOD - 1))))
		else $error("strobe spacing differs from the sample period");

	dac_silent: assert property (@(posedge CLK_IN) disable iff (!rst_n_i)
		underrun_o |-> !dac_o)
		else $error("dac output high during underrun");

	overrun_full: assert property (@(posedge CLK_IN) disable iff (!rst_n_i)
		overrun_o |-> (fill_o == FILL_BITS'(FIFO_DEPTH)))
		else $error("overrun pulse while the FIFO had room");

endmodule

`default_nettype wire

// File: tests/audio_stream_tb.sv
`timescale 1ns/1ps
`default_nettype none

module audio_stream_tb;
	import uart_pkg::*;
	import audio_pkg::*;

	localparam int RAND_SEED = 54;
	// sync flops and edge detect plus the run to the stop bit centre
	localparam int FRAME_LATENCY = 3 + HALF_BIT + (DATA_BITS + 1) * CLKS_PER_BIT;
	// about 200 bytes at one sample period each and doubled for margin
	localparam int TIMEOUT_CYCLES = 200 * SAMPLE_PERIOD * 2;

	logic CLK_IN;
	logic rst_n_i;
	logic uart_rx_i;
	logic uart_cts_o;
	logic dac_o;
	logic strobe_o;
	logic underrun_o;
	logic overrun_o;
	logic frame_err_o;
	fill_t fill_o;

	string test_name;
	logic running;
	logic cts_seen;
	int cyc;
	int ones;
	int n_ovr;
	int n_ferr;

	// frames on the line keyed by the cycle of their stop bit check
	int pend_cyc[$];
	sample_t pend_data[$];
	logic pend_good[$];
	sample_t model_fifo[$];
	// what each sample period should play
	sample_t exp_smp[$];
	logic exp_und[$];

	fill_t fill_now;
	logic model_cts;
	logic model_und;
	logic have_period;
	logic exp_strobe;
	logic exp_ovr;
	logic exp_ferr;
	logic wr;
	logic good;
	sample_t wr_data;
	sample_t cur_smp;

	audio_stream_top UUT (
		.CLK_IN      (CLK_IN),
		.rst_n_i     (rst_n_i),
		.uart_rx_i   (uart_rx_i),
		.uart_cts_o  (uart_cts_o),
		.dac_o       (dac_o),
		.strobe_o    (strobe_o),
		.underrun_o  (underrun_o),
		.overrun_o   (overrun_o),
		.frame_err_o (frame_err_o),
		.fill_o      (fill_o)
	);

	bind audio_stream_top audio_stream_chk u_chk (
		.CLK_IN     (CLK_IN),
		.rst_n_i    (rst_n_i),
		.dac_o      (dac_o),
		.strobe_o   (strobe_o),
		.underrun_o (underrun_o),
		.overrun_o  (overrun_o),
		.fill_o     (fill_o)
	);

	initial begin
		CLK_IN = 1'b0;
		forever #2 CLK_IN = ~CLK_IN;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_sample(input string what, input sample_t expected, input sample_t actual);
		if (actual !== expected)
			abort_run($sformatf("ERROR %s, %s: expected %0d, actual %0d",
				test_name, what, expected, actual));
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("ERROR %s, %s: expected %b, actual %b",
				test_name, what, expected, actual));
	endtask

	task automatic check_fill(input string what, input fill_t expected, input fill_t actual);
		if (actual !== expected)
			abort_run($sformatf("ERROR %s, %s: expected %0d, actual %0d",
				test_name, what, expected, actual));
	endtask

	task automatic idle_for(input int cycles);
		repeat (cycles) @(posedge CLK_IN);
	endtask

	// 8N1 frame sent lsb first with the stop bit level from the caller
	task automatic send_byte(input sample_t data, input logic good_stop);
		@(posedge CLK_IN);
		uart_rx_i <= 1'b0;
		pend_cyc.push_back(cyc + FRAME_LATENCY);
		pend_data.push_back(data);
		pend_good.push_back(good_stop);
		repeat (CLKS_PER_BIT) @(posedge CLK_IN);
		for (int i = 0; i < DATA_BITS; i++) begin
			uart_rx_i <= data[i];
			repeat (CLKS_PER_BIT) @(posedge CLK_IN);
		end
		uart_rx_i <= good_stop;
		repeat (CLKS_PER_BIT) @(posedge CLK_IN);
		uart_rx_i <= 1'b1;
		// a clean idle bit before the next start after a bad stop
		if (!good_stop)
			repeat (CLKS_PER_BIT) @(posedge CLK_IN);
	endtask

	task automatic wait_for_drain();
		while (model_fifo.size() != 0 || pend_cyc.size() != 0)
			@(posedge CLK_IN);
	endtask

	// reference model steps once per cycle at the falling edge
	always @(negedge CLK_IN) begin
		cts_seen = uart_cts_o;
		if (running) begin
			if (cyc >= TIMEOUT_CYCLES)
				abort_run("timeout: the test sequence did not finish in time");
			fill_now = fill_t'(model_fifo.size());
			check_fill("fill level", fill_now, fill_o);
			check_flag("clear to send", model_cts, uart_cts_o);
			exp_strobe = (cyc >= SAMPLE_PERIOD) && (cyc % SAMPLE_PERIOD == 0);
			check_flag("strobe", exp_strobe, strobe_o);
			if (exp_strobe) begin
				if (have_period)
					check_sample("ones per period", cur_smp, sample_t'(ones));
				cur_smp = exp_smp.pop_front();
				model_und = exp_und.pop_front();
				have_period = 1'b1;
				ones = 0;
			end
			check_flag("underrun", model_und, underrun_o);
			if (dac_o)
				ones++;

			// stop bit checked this cycle
			wr = 1'b0;
			exp_ovr = 1'b0;
			exp_ferr = 1'b0;
			if (pend_cyc.size() > 0 && pend_cyc[0] == cyc) begin
				void'(pend_cyc.pop_front());
				wr_data = pend_data.pop_front();
				good = pend_good.pop_front();
				if (!good) begin
					exp_ferr = 1'b1;
					n_ferr++;
				end else if (model_fifo.size() == FIFO_DEPTH) begin
					exp_ovr = 1'b1;
					n_ovr++;
				end else begin
					wr = 1'b1;
				end
			end
			check_flag("frame error", exp_ferr, frame_err_o);
			check_flag("overrun", exp_ovr, overrun_o);

			// player tick takes the head before this cycle's write lands
			if (cyc % SAMPLE_PERIOD == SAMPLE_PERIOD - 1) begin
				if (model_fifo.size() > 0) begin
					exp_smp.push_back(model_fifo.pop_front());
					exp_und.push_back(1'b0);
				end else begin
					exp_smp.push_back('0);
					exp_und.push_back(1'b1);
				end
			end
			if (wr)
				model_fifo.push_back(wr_data);
			if (fill_now >= FILL_BITS'(HIGH_MARK))
				model_cts = 1'b0;
			else if (fill_now <= FILL_BITS'(LOW_MARK))
				model_cts = 1'b1;
			cyc++;
		end
	end

	initial begin
		void'($urandom(RAND_SEED));
		rst_n_i = 1'b0;
		uart_rx_i = 1'b1;
		running = 1'b0;
		cts_seen = 1'b1;
		cyc = 0;
		ones = 0;
		n_ovr = 0;
		n_ferr = 0;
		model_cts = 1'b1;
		model_und = 1'b1;
		have_period = 1'b0;
		test_name = "reset";
		repeat (4) @(posedge CLK_IN);
		rst_n_i <= 1'b1;
		running = 1'b1;

		test_name = "startup underrun";
		idle_for(2 * SAMPLE_PERIOD + 100);

		// sender obeys cts and runs faster than playback so the FIFO fills
		test_name = "paced playback";
		repeat (60) begin
			while (!cts_seen)
				@(posedge CLK_IN);
			send_byte(sample_t'($urandom), ($urandom % 8) != 0);
			idle_for($urandom % 64);
		end

		test_name = "quiet underrun";
		wait_for_drain();
		idle_for(3 * SAMPLE_PERIOD);

		// back to back with cts ignored
		test_name = "overrun burst";
		repeat (70)
			send_byte(sample_t'($urandom), 1'b1);

		test_name = "final drain";
		wait_for_drain();
		idle_for(2 * SAMPLE_PERIOD);
		if (n_ovr == 0)
			abort_run("the overrun burst never filled the FIFO");
		else if (n_ferr == 0)
			abort_run("no frame with a low stop bit was sent");
		else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: src.f
common/uart_pkg.sv
common/audio_pkg.sv
uart_rx/uart_rx.sv
sample_fifo/sample_fifo.sv
verilog/flow_ctrl.sv
verilog/sample_player.sv
verilog/audio_stream_top.sv
tests/audio_stream_chk.sv
tests/audio_stream_tb.sv

// File: Makefile
# Verilator build for the audio stream testbench

VERILATOR ?= verilator
TOP       ?= audio_stream_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SEED      ?= 54

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# $fatal in the testbench gives a failing exit status
run: compile
	$(SIM) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD_DIR)
